//--- Bender.yml
package:
  name: clock_ctrl

sources:
  # Package first, then modules bottom up
  - source/clock_ctrl_pkg.sv
  - source/phase_step_rom.sv
  - source/phaser.sv
  - source/global_reset_gen.sv
  - source/clock_activity_monitor.sv
  - source/clock_ctrl.sv
  - target: test
    files:
      - tests/tb_clock_ctrl.sv

//--- source/clock_activity_monitor.sv
`timescale 1ns/1ps

module clock_activity_monitor (
	input  logic                               clock,
	input  logic                               rst_n,
	input  logic [clock_ctrl_pkg::NUM_MON-1:0] mon_clocks,
	output logic [clock_ctrl_pkg::NUM_MON-1:0] mon_active
);
	import clock_ctrl_pkg::*;

//----------------------------------------------------------------------
// Dual edge samples
//----------------------------------------------------------------------
	logic [NUM_MON-1:0] rise_q;	// Sampled on rising edge
	logic [NUM_MON-1:0] fall_q;	// Sampled on falling edge

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rise_q <= '0;
		end else begin
			rise_q <= mon_clocks;
		end
	end

	always_ff @(negedge clock) begin
		if (!rst_n) begin
			fall_q <= '0;
		end else begin
			fall_q <= mon_clocks;
		end
	end

	// A running clock differs between the two half cycles
	assign mon_active = rise_q ^ fall_q;	// Stopped clock gives 0

endmodule

//--- source/clock_ctrl.sv
`timescale 1ns/1ps

module clock_ctrl (
	input  logic                                                  clock,
	input  logic                                                  rst_n,
	input  logic                                                  lock_main,
	input  logic                                                  global_reset_en,
	input  clock_ctrl_pkg::dps_ctrl_t   [clock_ctrl_pkg::NUM_DPS-1:0] dps_ctrl,
	input  logic                        [clock_ctrl_pkg::NUM_DPS-1:0] dps_lock,
	input  logic                        [clock_ctrl_pkg::NUM_DPS-1:0] ps_done,
	input  logic                        [clock_ctrl_pkg::NUM_MON-1:0] mon_clocks,
	output clock_ctrl_pkg::ps_port_t    [clock_ctrl_pkg::NUM_DPS-1:0] ps_cmd,
	output clock_ctrl_pkg::dps_status_t [clock_ctrl_pkg::NUM_DPS-1:0] dps_status,
	output logic                                                  global_reset,
	output logic                                                  clock_lock_lost_err,
	output logic                        [clock_ctrl_pkg::NUM_MON-1:0] mon_active
);
	import clock_ctrl_pkg::*;

//----------------------------------------------------------------------
// Global reset from main PLL lock
//----------------------------------------------------------------------
	global_reset_gen u_global_reset_gen (
		.clock               (clock),
		.rst_n               (rst_n),
		.lock_main           (lock_main),	// Main PLL lock
		.global_reset_en     (global_reset_en),	// Refire on lock lost
		.global_reset        (global_reset),	// Also feeds every phaser
		.clock_lock_lost_err (clock_lock_lost_err)
	);

//----------------------------------------------------------------------
// Aux clock activity
//----------------------------------------------------------------------
	clock_activity_monitor u_activity (
		.clock      (clock),
		.rst_n      (rst_n),
		.mon_clocks (mon_clocks),	// Raw aux clocks
		.mon_active (mon_active)	// 1 = toggling
	);

//----------------------------------------------------------------------
// Phase shifter channels
//----------------------------------------------------------------------
	for (genvar i = 0; i < NUM_DPS; i++) begin : g_dps
		phaser u_phaser (
			.clock        (clock),
			.rst_n        (rst_n),
			.global_reset (global_reset),	// Hold until main lock
			.lock_main    (lock_main),
			.lock_dcm     (dps_lock[i]),	// This channel PLL lock
			.ctrl         (dps_ctrl[i]),	// Fire, reset, phase
			.ps_done      (ps_done[i]),	// PLL step acknowledge
			.ps_cmd       (ps_cmd[i]),	// Shift enable and direction
			.status       (dps_status[i])	// Busy and state
		);
	end

endmodule

//--- source/clock_ctrl_pkg.sv
package clock_ctrl_pkg;

//----------------------------------------------------------------------
// Sizes
//----------------------------------------------------------------------
	localparam int NUM_DPS      = 4;	// Phase shifter channels
	localparam int NUM_MON      = 7;	// Monitored aux clocks
	localparam int COARSE_W     = 8;	// Requested phase width
	localparam int FINE_W       = 11;	// Fine step target width
	localparam int FINE_STEPS   = 1400;	// PLL fine steps per clock period
	localparam int COARSE_STEPS = 256;	// Coarse steps per clock period

//----------------------------------------------------------------------
// Phase words
//----------------------------------------------------------------------
	typedef logic [COARSE_W-1:0] coarse_phase_t;	// 0 to 255
	typedef logic [FINE_W-1:0]   fine_phase_t;	// 0 to 1399

//----------------------------------------------------------------------
// Phaser state machine
//----------------------------------------------------------------------
	typedef enum logic [2:0] {
		IDLE      = 3'd0,	// Ready for fire
		WAIT_LOCK = 3'd1,	// Held until all locks good
		LOAD      = 3'd2,	// Latch table target
		STEP      = 3'd3,	// Issue one shift enable
		WAIT_DONE = 3'd4,	// Wait for PLL done
		FINISH    = 3'd5	// Hold until fire drops
	} dps_state_t;

//----------------------------------------------------------------------
// Channel command and status
//----------------------------------------------------------------------
	typedef struct packed {
		logic          fire;	// Level that starts a move
		logic          reset;	// Level that zeroes tracked phase
		coarse_phase_t phase;	// Requested phase
	} dps_ctrl_t;

	typedef struct packed {
		logic psen;		// One cycle shift enable
		logic psincdec;	// 1 = increment
	} ps_port_t;

	typedef struct packed {
		logic       busy;	// Move in progress
		dps_state_t sm_vec;	// Machine state
	} dps_status_t;

endpackage

//--- source/global_reset_gen.sv
`timescale 1ns/1ps

module global_reset_gen (
	input  logic clock,
	input  logic rst_n,
	input  logic lock_main,
	input  logic global_reset_en,
	output logic global_reset,
	output logic clock_lock_lost_err
);

//----------------------------------------------------------------------
// Startup and lock tracking
//----------------------------------------------------------------------
	logic startup_done;	// Set on first main lock
	logic first_lock;	// Locked now or has been

	assign first_lock = lock_main || startup_done;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			startup_done <= 1'b0;
			global_reset <= 1'b1;	// Held until main PLL locks
		end else begin
			startup_done <= first_lock;	// Sticks after first lock
			global_reset <= !first_lock || (!lock_main && global_reset_en);	// Refire if enabled
		end
	end

	// Lock dropped after startup without a refired reset
	assign clock_lock_lost_err = !global_reset && !lock_main;

//----------------------------------------------------------------------
// Checks
//----------------------------------------------------------------------
	a_reset_after_rst_n: assert property (
		@(posedge clock)
		$rose(rst_n) |-> global_reset
	);

endmodule

//--- source/phase_step_rom.sv
`timescale 1ns/1ps

module phase_step_rom (
	input  clock_ctrl_pkg::coarse_phase_t addr,
	output clock_ctrl_pkg::fine_phase_t   steps
);
	import clock_ctrl_pkg::*;

//----------------------------------------------------------------------
// Coarse to fine conversion, rounded half up
//----------------------------------------------------------------------
	function automatic fine_phase_t round_step(input int unsigned n);
		int unsigned scaled;
		scaled = n * FINE_STEPS + COARSE_STEPS / 2;	// Add half a coarse step
		return fine_phase_t'(scaled / COARSE_STEPS);	// Entry 255 gives 1395
	endfunction

	fine_phase_t rom [COARSE_STEPS];	// Constant table

	always_comb begin
		for (int i = 0; i < COARSE_STEPS; i++) begin
			rom[i] = round_step(i);	// Integer math only
		end
	end

	assign steps = rom[addr];	// Table lookup

endmodule

//--- source/phaser.sv
`timescale 1ns/1ps

module phaser (
	input  logic                        clock,
	input  logic                        rst_n,
	input  logic                        global_reset,
	input  logic                        lock_main,
	input  logic                        lock_dcm,
	input  clock_ctrl_pkg::dps_ctrl_t   ctrl,
	input  logic                        ps_done,
	output clock_ctrl_pkg::ps_port_t    ps_cmd,
	output clock_ctrl_pkg::dps_status_t status
);
	import clock_ctrl_pkg::*;

//----------------------------------------------------------------------
// Declarations
//----------------------------------------------------------------------
	dps_state_t  state;		// Current state
	dps_state_t  state_nxt;	// Next state
	fine_phase_t rom_steps;	// Target for requested phase
	fine_phase_t target;	// Latched target
	fine_phase_t cur_phase;	// Phase the PLL is at now
	fine_phase_t step_phase;	// Phase after one more step
	logic        dir_up;	// Move direction for this fire
	logic        psen_q;	// Registered shift enable
	logic        locked;	// Main and channel PLL good

//----------------------------------------------------------------------
// Phase table
//----------------------------------------------------------------------
	phase_step_rom u_rom (
		.addr  (ctrl.phase),	// Requested 0 to 255
		.steps (rom_steps)	// Fine steps 0 to 1395
	);

	assign locked     = !global_reset && lock_main && lock_dcm;	// Run condition
	assign step_phase = dir_up ? cur_phase + 1'b1 : cur_phase - 1'b1;

//----------------------------------------------------------------------
// Next state
//----------------------------------------------------------------------
	always_comb begin
		state_nxt = state;	// Hold by default
		case (state)
			WAIT_LOCK: begin
				if (locked) state_nxt = IDLE;	// All clocks good
			end
			IDLE: begin
				if (ctrl.fire) state_nxt = LOAD;	// New request
			end
			LOAD: begin
				// Already there so no pulses at all
				state_nxt = (rom_steps == cur_phase) ? FINISH : STEP;
			end
			STEP: begin
				state_nxt = WAIT_DONE;	// Pulse goes out now
			end
			WAIT_DONE: begin
				if (ps_done) begin
					state_nxt = (step_phase == target) ? FINISH : STEP;
				end
			end
			FINISH: begin
				if (!ctrl.fire) state_nxt = IDLE;	// Wait for fire release
			end
			default: begin
				state_nxt = WAIT_LOCK;	// Unused codes
			end
		endcase
		if (ctrl.reset || !locked) state_nxt = WAIT_LOCK;	// Reset or lock lost wins
	end

//----------------------------------------------------------------------
// State and phase tracking
//----------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= WAIT_LOCK;
			cur_phase <= '0;
			dir_up    <= 1'b0;
			psen_q    <= 1'b0;
		end else begin
			state  <= state_nxt;
			psen_q <= (state_nxt == STEP);	// High for the one STEP cycle
			if (ctrl.reset) begin
				cur_phase <= '0;	// PLL restarts at zero phase
			end else if (state == WAIT_DONE && ps_done) begin
				cur_phase <= step_phase;	// PLL moved one step
			end
			if (state == LOAD) begin
				dir_up <= (rom_steps > cur_phase);	// Fixed for the whole move
			end
		end
	end

	always_ff @(posedge clock) begin
		if (state == LOAD) target <= rom_steps;	// Hold target during move
	end

//----------------------------------------------------------------------
// Outputs
//----------------------------------------------------------------------
	assign ps_cmd.psen     = psen_q;
	assign ps_cmd.psincdec = dir_up;
	assign status.busy     = (state == LOAD) || (state == STEP) || (state == WAIT_DONE);
	assign status.sm_vec   = state;

//----------------------------------------------------------------------
// Checks
//----------------------------------------------------------------------
	a_psen_one_cycle: assert property (
		@(posedge clock) disable iff (!rst_n)
		ps_cmd.psen |=> !ps_cmd.psen
	);

	// No new shift until the previous one is acknowledged
	a_psen_waits_done: assert property (
		@(posedge clock) disable iff (!rst_n)
		(state == WAIT_DONE && !ps_done && !ctrl.reset) |=> !ps_cmd.psen
	);

	a_state_legal: assert property (
		@(posedge clock) disable iff (!rst_n)
		3'(state) < 3'd6
	);

endmodule

//--- tests/tb_clock_ctrl.sv
`timescale 1ns/1ps

module tb_clock_ctrl;
	import clock_ctrl_pkg::*;

	localparam int CLK_PERIOD  = 20;	// ns
	localparam int MOVE_LIMIT  = FINE_STEPS * 6;	// Full range move at slowest PLL
	localparam     STIM_FILE   = "tests/tb_clock_ctrl_input.txt";
	localparam int OP_FIRE     = 0;
	localparam int OP_DPSRST   = 1;
	localparam int OP_MAINLOCK = 2;
	localparam int OP_MONSET   = 3;

//----------------------------------------------------------------------
// DUT signals
//----------------------------------------------------------------------
	logic                      clock;
	logic                      rst_n;
	logic                      lock_main;
	logic                      global_reset_en;
	dps_ctrl_t   [NUM_DPS-1:0] dps_ctrl;
	logic        [NUM_DPS-1:0] dps_lock;
	logic        [NUM_DPS-1:0] ps_done;
	logic        [NUM_MON-1:0] mon_clocks;
	ps_port_t    [NUM_DPS-1:0] ps_cmd;
	dps_status_t [NUM_DPS-1:0] dps_status;
	logic                      global_reset;
	logic                      clock_lock_lost_err;
	logic        [NUM_MON-1:0] mon_active;

//----------------------------------------------------------------------
// Testbench state
//----------------------------------------------------------------------
	logic               aux_clock;	// Quarter period behind clock
	logic [NUM_MON-1:0] run_mask;	// Aux clocks that run
	integer             seed = 65;	// PLL done delay
	int                 done_wait [NUM_DPS];	// Cycles until ps_done
	fine_phase_t        up_count [NUM_DPS];	// psen seen with psincdec high
	fine_phase_t        down_count [NUM_DPS];	// psen seen with psincdec low
	fine_phase_t        model_phase [NUM_DPS];	// Where each PLL should be
	fine_phase_t        exp_up [NUM_DPS];
	fine_phase_t        exp_down [NUM_DPS];
	logic [NUM_DPS-1:0] in_flight;	// Fired but not yet checked
	logic [NUM_DPS-1:0] busy_seen;	// Busy observed during the move
	logic               gr_model;	// Expected global_reset so far
	int                 flight_test [NUM_DPS];
	int                 launch_err [NUM_DPS];
	int                 test_op [$];
	int                 test_ch [$];
	logic [15:0]        test_arg [$];
	logic [15:0]        test_exp [$];
	int                 num_tests;
	int                 checks;
	int                 errors;
	logic               file_ok;
	logic               tests_loaded;

	clock_ctrl uut (
		.clock               (clock),
		.rst_n               (rst_n),
		.lock_main           (lock_main),
		.global_reset_en     (global_reset_en),
		.dps_ctrl            (dps_ctrl),
		.dps_lock            (dps_lock),
		.ps_done             (ps_done),
		.mon_clocks          (mon_clocks),
		.ps_cmd              (ps_cmd),
		.dps_status          (dps_status),
		.global_reset        (global_reset),
		.clock_lock_lost_err (clock_lock_lost_err),
		.mon_active          (mon_active)
	);

//----------------------------------------------------------------------
// Clocks and PLL models
//----------------------------------------------------------------------
	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	initial begin
		aux_clock = 1'b0;
		#(CLK_PERIOD / 4);	// Quarter period shift
		forever #(CLK_PERIOD / 2) aux_clock = ~aux_clock;
	end

	assign mon_clocks = run_mask & {NUM_MON{aux_clock}};	// Stopped clocks held low

	for (genvar g = 0; g < NUM_DPS; g++) begin : g_pll
		assign dps_lock[g] = !dps_ctrl[g].reset;	// Channel PLL unlocks in reset
	end

	always @(negedge clock) begin
		for (int i = 0; i < NUM_DPS; i++) begin
			ps_done[i] = 1'b0;	// Done is a single cycle pulse
			if (dps_ctrl[i].reset) begin
				done_wait[i] = 0;	// Pending step lost
			end else if (ps_cmd[i].psen) begin
				done_wait[i] = 1 + ($unsigned($random(seed)) % 4);	// 1 to 4 cycles
				if (ps_cmd[i].psincdec) up_count[i] = up_count[i] + 1'b1;
				else down_count[i] = down_count[i] + 1'b1;
			end else if (done_wait[i] != 0) begin
				done_wait[i] = done_wait[i] - 1;
				if (done_wait[i] == 0) ps_done[i] = 1'b1;
			end
		end
	end

	// LOAD shows busy on every fire
	always @(negedge clock) begin
		for (int i = 0; i < NUM_DPS; i++) begin
			if (in_flight[i] && dps_status[i].busy) busy_seen[i] = 1'b1;
		end
	end

//----------------------------------------------------------------------
// Reference rules and compare tasks
//----------------------------------------------------------------------
	function automatic fine_phase_t table_steps(input int unsigned p);
		int unsigned twice;
		twice = 2 * p * FINE_STEPS + COARSE_STEPS;	// Doubled plus one half step
		return fine_phase_t'(twice / (2 * COARSE_STEPS));
	endfunction

	function automatic dps_status_t make_status(input logic busy, input dps_state_t st);
		dps_status_t s;
		s.busy   = busy;
		s.sm_vec = st;
		return s;
	endfunction

	function automatic string op_name(input int op);
		case (op)
			OP_FIRE:     return "FIRE";
			OP_DPSRST:   return "DPSRST";
			OP_MAINLOCK: return "MAINLOCK";
			default:     return "MONSET";
		endcase
	endfunction

	task automatic check_status(input string name, input dps_status_t got,
			input dps_status_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %0s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input fine_phase_t got,
			input fine_phase_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %0s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic [NUM_MON-1:0] got,
			input logic [NUM_MON-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %0s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(input int idx, input logic ok);
		$display("Test %0d %0s ch %0d arg %h: %0s", idx, op_name(test_op[idx]), test_ch[idx],
			test_arg[idx], ok ? "ok" : "failed");
	endtask

//----------------------------------------------------------------------
// Stimulus file
//----------------------------------------------------------------------
	task automatic load_tests();
		int              fd;
		int              r;
		int              op;
		int              ch;
		logic [15:0]     arg;
		logic [15:0]     exp_val;
		logic [8*12-1:0] word;
		logic [8*160-1:0] rest;
		fd      = $fopen(STIM_FILE, "r");
		file_ok = (fd != 0);
		if (fd != 0) begin
			r = $fscanf(fd, "%s", word);
			while (r == 1) begin
				if (word == "#") begin
					r = $fgets(rest, fd);	// Skip comment line
				end else begin
					r = $fscanf(fd, "%d %h %h", ch, arg, exp_val);
					if (word == "FIRE") op = OP_FIRE;
					else if (word == "DPSRST") op = OP_DPSRST;
					else if (word == "MAINLOCK") op = OP_MAINLOCK;
					else if (word == "MONSET") op = OP_MONSET;
					else op = -1;
					if (r != 3 || op < 0 || ch < 0 || ch >= NUM_DPS) begin
						errors++;
						$display("Stimulus line after test %0d cannot be parsed", test_op.size());
					end else begin
						test_op.push_back(op);
						test_ch.push_back(ch);
						test_arg.push_back(arg);
						test_exp.push_back(exp_val);
					end
				end
				r = $fscanf(fd, "%s", word);
			end
			$fclose(fd);
		end
		num_tests    = test_op.size();
		tests_loaded = 1'b1;	// Starts the watchdog
	endtask

//----------------------------------------------------------------------
// Operations
//----------------------------------------------------------------------
	function automatic logic moves_finished();
		logic all_done;
		all_done = 1'b1;
		for (int i = 0; i < NUM_DPS; i++) begin
			if (in_flight[i] && dps_status[i].sm_vec != FINISH) all_done = 1'b0;
		end
		return all_done;
	endfunction

	task automatic launch_fire(input int idx);
		int          ch;
		int          waited;
		int          mark;
		fine_phase_t target;
		ch     = test_ch[idx];
		mark   = errors;
		target = table_steps(test_arg[idx][COARSE_W-1:0]);
		check_count("file target", fine_phase_t'(test_exp[idx]), target);
		waited = 0;
		@(negedge clock);
		while (dps_status[ch].sm_vec != IDLE && waited < MOVE_LIMIT) begin	// After a lock loss
			@(negedge clock);
			waited++;
		end
		if (dps_status[ch].sm_vec != IDLE) begin
			errors++;
			$display("Channel %0d did not return to idle before test %0d", ch, idx);
		end
		exp_up[ch]         = (target > model_phase[ch]) ? target - model_phase[ch] : '0;
		exp_down[ch]       = (target < model_phase[ch]) ? model_phase[ch] - target : '0;
		model_phase[ch]    = target;
		up_count[ch]       = '0;
		down_count[ch]     = '0;
		busy_seen[ch]      = 1'b0;
		dps_ctrl[ch].phase = test_arg[idx][COARSE_W-1:0];
		dps_ctrl[ch].fire  = 1'b1;	// Held until the move is checked
		in_flight[ch]      = 1'b1;
		flight_test[ch]    = idx;
		launch_err[ch]     = errors - mark;
	endtask

	task automatic finish_moves();
		int waited;
		int mark;
		int fails [NUM_DPS];
		waited = 0;
		while (!moves_finished() && waited < MOVE_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (!moves_finished()) begin
			errors++;
			$display("Phase move did not finish within %0d cycles", MOVE_LIMIT);
		end
		for (int i = 0; i < NUM_DPS; i++) begin
			fails[i] = 0;
			if (in_flight[i]) begin
				mark = errors;
				check_status($sformatf("dps_status[%0d]", i), dps_status[i],
					make_status(1'b0, FINISH));
				check_bit($sformatf("dps_status[%0d].busy seen", i), busy_seen[i], 1'b1);
				check_count($sformatf("psen up count[%0d]", i), up_count[i], exp_up[i]);
				check_count($sformatf("psen down count[%0d]", i), down_count[i], exp_down[i]);
				dps_ctrl[i].fire = 1'b0;	// Release so FINISH goes to IDLE
				fails[i]         = errors - mark;
			end
		end
		if (in_flight != '0) @(negedge clock);
		for (int i = 0; i < NUM_DPS; i++) begin
			if (in_flight[i]) begin
				mark = errors;
				check_status($sformatf("dps_status[%0d]", i), dps_status[i],
					make_status(1'b0, IDLE));
				report_test(flight_test[i],
					errors == mark && fails[i] == 0 && launch_err[i] == 0);
			end
		end
		in_flight = '0;
	endtask

	task automatic reset_channel(input int idx);
		int ch;
		int mark;
		ch   = test_ch[idx];
		mark = errors;
		check_status("file state", dps_status_t'(test_exp[idx][3:0]),
			make_status(1'b0, WAIT_LOCK));
		@(negedge clock);
		dps_ctrl[ch].reset = 1'b1;	// PLL model drops lock too
		repeat (2) @(negedge clock);
		check_status($sformatf("dps_status[%0d]", ch), dps_status[ch],
			make_status(1'b0, WAIT_LOCK));
		dps_ctrl[ch].reset = 1'b0;
		model_phase[ch]    = '0;	// PLL restarts at zero phase
		@(negedge clock);	// Lock back so one edge to IDLE
		check_status($sformatf("dps_status[%0d]", ch), dps_status[ch],
			make_status(1'b0, IDLE));
		report_test(idx, errors == mark);
	endtask

	task automatic change_main_lock(input int idx);
		int   mark;
		logic exp_gr;
		logic exp_err;
		mark    = errors;
		exp_gr  = !test_arg[idx][0] && test_ch[idx][0];	// Refire only when enabled
		exp_err = !exp_gr && !test_arg[idx][0];
		check_bit("file global flags", test_exp[idx][NUM_MON-1:0], {exp_err, exp_gr});
		@(negedge clock);
		global_reset_en = test_ch[idx][0];
		lock_main       = test_arg[idx][0];
		#(CLK_PERIOD / 4);	// Before the sampling edge
		check_bit("global_reset", global_reset, gr_model);
		@(negedge clock);	// One sampling edge later
		check_bit("global_reset", global_reset, exp_gr);
		check_bit("clock_lock_lost_err", clock_lock_lost_err, exp_err);
		gr_model = exp_gr;
		report_test(idx, errors == mark);
	endtask

	task automatic apply_mon_mask(input int idx);
		int                 mark;
		logic [NUM_MON-1:0] pattern;
		mark    = errors;
		pattern = test_arg[idx][NUM_MON-1:0];	// Running clocks show as active
		check_bit("file mon_active", test_exp[idx][NUM_MON-1:0], pattern);
		@(negedge clock);
		run_mask = pattern;
		repeat (5) @(negedge clock);
		#(CLK_PERIOD / 10);	// Away from the falling edge sample
		check_bit("mon_active", mon_active, pattern);
		report_test(idx, errors == mark);
	endtask

//----------------------------------------------------------------------
// Main sequence and watchdog
//----------------------------------------------------------------------
	initial begin
		rst_n           = 1'b0;
		lock_main       = 1'b0;	// Main PLL not locked yet
		global_reset_en = 1'b1;
		dps_ctrl        = '0;
		ps_done         = '0;
		run_mask        = '0;
		in_flight       = '0;
		busy_seen       = '0;
		gr_model        = 1'b1;
		checks          = 0;
		errors          = 0;
		tests_loaded    = 1'b0;
		for (int i = 0; i < NUM_DPS; i++) begin
			done_wait[i]   = 0;
			up_count[i]    = '0;
			down_count[i]  = '0;
			model_phase[i] = '0;
		end
		load_tests();
		if (!file_ok) begin
			$display("Stimulus file %0s could not be opened", STIM_FILE);
			$display("TB FAILED");
			$finish;
		end else begin
			repeat (16) @(negedge clock);
			rst_n = 1'b1;
			repeat (8) begin
				@(negedge clock);
				check_bit("global_reset", global_reset, 1'b1);	// Held while unlocked
			end
			for (int i = 0; i < NUM_DPS; i++) begin
				check_status($sformatf("dps_status[%0d]", i), dps_status[i],
					make_status(1'b0, WAIT_LOCK));
			end
			for (int idx = 0; idx < num_tests; idx++) begin
				if (test_op[idx] == OP_FIRE) begin
					if (in_flight[test_ch[idx]]) finish_moves();	// Same channel busy
					launch_fire(idx);
				end else begin
					finish_moves();
					case (test_op[idx])
						OP_DPSRST:   reset_channel(idx);
						OP_MAINLOCK: change_main_lock(idx);
						default:     apply_mon_mask(idx);
					endcase
				end
			end
			finish_moves();
			$display("Summary: %0d tests, %0d checks, %0d errors", num_tests, checks, errors);
			if (errors == 0) begin
				$display("TB PASSED");
			end else begin
				$display("TB FAILED");
			end
			$finish;
		end
	end

	initial begin
		wait (tests_loaded === 1'b1);
		repeat (num_tests * MOVE_LIMIT + 100) @(posedge clock);
		$display("Watchdog expired after %0d cycles, run did not complete",
			num_tests * MOVE_LIMIT + 100);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- tests/tb_clock_ctrl_input.txt
# columns: operation, channel, argument (hex), expected value (hex)
# FIRE phase and fine target, DPSRST state in reset, MAINLOCK en/lock/{err,global_reset}, MONSET mask
# main PLL locks, global reset released
MAINLOCK 1 1 0
# first moves from zero, all channels together
FIRE 0 40 15e
FIRE 1 10 058
FIRE 2 ff 573
FIRE 3 01 005
# second moves, both directions
FIRE 0 80 2bc
FIRE 1 03 010
FIRE 2 c0 41a
FIRE 3 30 107
# fire to the phase already held, no pulses
FIRE 0 80 2bc
FIRE 3 30 107
# downward moves
FIRE 0 20 0af
FIRE 2 25 0ca
# channel reset, then count from zero while others move
DPSRST 1 0 1
FIRE 1 0b 03c
FIRE 0 60 20d
FIRE 3 07 026
DPSRST 2 0 1
FIRE 2 09 031
# aux clock activity
MONSET 0 7f 7f
MONSET 0 00 00
MONSET 0 55 55
MONSET 0 2a 2a
# lock lost with reset refire enabled
MAINLOCK 1 0 1
MAINLOCK 1 1 0
# lock lost with refire disabled
MAINLOCK 0 0 2
MAINLOCK 0 1 0
# phase kept across lock loss
FIRE 0 40 15e
FIRE 1 00 000
FIRE 3 ff 573

//--- vlog.f
source/clock_ctrl_pkg.sv
source/phase_step_rom.sv
source/phaser.sv
source/global_reset_gen.sv
source/clock_activity_monitor.sv
source/clock_ctrl.sv
tests/tb_clock_ctrl.sv
